//--- source/ex_cfg_pkg.sv
// execute stage configuration: datapath, register address and shift widths
package ex_cfg_pkg;

  //////////////////////////////
  // datapath
  //////////////////////////////

  // one machine word
  localparam int unsigned DATA_W = 32;

  // shift amount taken from the low bits of operand b
  localparam int unsigned SHAMT_W = 5;

  //////////////////////////////
  // register file
  //////////////////////////////

  // integer and fp register spaces share one address range
  // msb selects the fp half
  localparam int unsigned REG_ADDR_W = 6;

endpackage : ex_cfg_pkg

//--- source/ex_types_pkg.sv
// execute stage opcode and multiplier state encodings
package ex_types_pkg;

  // alu opcodes
  // arithmetic and logic in the low range, branch compares from 5'h10
  typedef enum logic [4:0] {
    ALU_ADD  = 5'h00,
    ALU_SUB  = 5'h01,
    ALU_AND  = 5'h02,
    ALU_OR   = 5'h03,
    ALU_XOR  = 5'h04,
    ALU_SLL  = 5'h05,
    ALU_SRL  = 5'h06,
    ALU_SRA  = 5'h07,
    ALU_SLT  = 5'h08,
    ALU_SLTU = 5'h09,
    ALU_EQ   = 5'h10,
    ALU_NE   = 5'h11,
    ALU_LT   = 5'h12,
    ALU_GE   = 5'h13,
    ALU_LTU  = 5'h14,
    ALU_GEU  = 5'h15
  } alu_op_e;

  // multiplier opcodes
  // mul is the low word, the rest return the high word
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  // multiplier control
  typedef enum logic {
    MS_IDLE = 1'b0,
    MS_HIGH = 1'b1
  } mult_state_e;

endpackage : ex_types_pkg

//--- source/ex_alu.sv
// integer alu with shared compare logic for slt and branch decisions
module ex_alu (
  input  logic                          enable_i,
  input  ex_types_pkg::alu_op_e         operator_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0] operand_a_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0] operand_b_i,
  output logic [ex_cfg_pkg::DATA_W-1:0] result_o,
  output logic                          comparison_result_o,
  output logic                          ready_o
);
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;
  logic               equal;
  logic               cmp_flag;

  //////////////////////////////
  // shared comparator
  //////////////////////////////

  // computed once, used by slt/sltu and all branch compares
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;
  assign equal       = operand_a_i == operand_b_i;

  always_comb begin
    unique case (operator_i)
      ALU_SLT, ALU_LT:   cmp_flag = lt_signed;
      ALU_SLTU, ALU_LTU: cmp_flag = lt_unsigned;
      ALU_GE:            cmp_flag = ~lt_signed;
      ALU_GEU:           cmp_flag = ~lt_unsigned;
      ALU_EQ:            cmp_flag = equal;
      ALU_NE:            cmp_flag = ~equal;
      default:           cmp_flag = 1'b0;
    endcase
  end

  // branch decision straight to IF
  assign comparison_result_o = cmp_flag;

  //////////////////////////////
  // result mux
  //////////////////////////////

  // rv32 shifts only look at the low bits
  assign shamt = operand_b_i[SHAMT_W-1:0];

  always_comb begin
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLL: result_o = operand_a_i << shamt;
      ALU_SRL: result_o = operand_a_i >> shamt;
      ALU_SRA: result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // compares give the flag zero extended
      default: result_o = {{(DATA_W-1){1'b0}}, cmp_flag};
    endcase
  end

  // single cycle unit, never stalls
  assign ready_o = 1'b1;

  // opcode must decode to a real operation when issued
  always_comb begin
    if (enable_i) begin
      a_op_known : assert (operator_i inside {[ALU_ADD:ALU_SLTU], [ALU_EQ:ALU_GEU]})
        else $error("alu issued with unknown opcode %0h", operator_i);
    end
  end

endmodule : ex_alu

//--- source/ex_mult.sv
// multiplier with single cycle low product and two cycle high product
module ex_mult (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          enable_i,
  input  ex_types_pkg::mul_op_e         operator_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0] op_a_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0] op_b_i,
  input  logic                          ex_ready_i,
  output logic [ex_cfg_pkg::DATA_W-1:0] result_o,
  output logic                          multicycle_o,
  output logic                          ready_o
);
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;

  mult_state_e                state_q;
  mult_state_e                state_d;
  logic                       sign_a;
  logic                       sign_b;
  logic                       high_req;
  logic signed [DATA_W:0]     a_ext;
  logic signed [DATA_W:0]     b_ext;
  logic signed [2*DATA_W-1:0] prod;
  logic [DATA_W-1:0]          prod_hi_q;

  //////////////////////////////
  // operand extension
  //////////////////////////////

  // mulh signs both, mulhsu only a, mulhu neither
  assign sign_a = (operator_i == MUL_MULH) || (operator_i == MUL_MULHSU);
  assign sign_b = (operator_i == MUL_MULH);

  assign a_ext = $signed({sign_a & op_a_i[DATA_W-1], op_a_i});
  assign b_ext = $signed({sign_b & op_b_i[DATA_W-1], op_b_i});

  // one 33x33 signed array
  // low word is the same for every signedness
  assign prod = a_ext * b_ext;

  // a new high product request
  assign high_req = enable_i && (operator_i != MUL_MUL);

  //////////////////////////////
  // control
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MS_IDLE: if (high_req) state_d = MS_HIGH;
      // hold until the stage hands off
      MS_HIGH: if (ex_ready_i) state_d = MS_IDLE;
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // upper word captured on entry to MS_HIGH
  always_ff @(posedge clk) begin
    if (state_q == MS_IDLE && high_req) begin
      prod_hi_q <= prod[2*DATA_W-1:DATA_W];
    end
  end

  assign multicycle_o = (state_q == MS_HIGH);
  // busy only in the cycle that starts a high product
  assign ready_o      = (state_q == MS_HIGH) || !high_req;
  assign result_o     = (state_q == MS_HIGH) ? prod_hi_q : prod[DATA_W-1:0];

  // stalled high result must not move
  a_high_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == MS_HIGH && !ex_ready_i) |=> $stable(result_o))
    else $error("mult high result changed while stalled");

endmodule : ex_mult

//--- source/ex_writeback.sv
// write port muxing, ex/wb register for the lsu port and stage handshake
module ex_writeback (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              alu_en_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     alu_result_i,
  input  logic                              mult_en_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     mult_result_i,
  input  logic                              csr_access_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     csr_rdata_i,
  input  logic                              lsu_en_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     lsu_rdata_i,
  input  logic                              lsu_ready_ex_i,
  input  logic                              lsu_err_i,
  input  logic                              alu_ready_i,
  input  logic                              mult_ready_i,
  input  logic                              branch_in_ex_i,
  input  logic                              regfile_alu_we_i,
  input  logic [ex_cfg_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                              regfile_we_i,
  input  logic [ex_cfg_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                              wb_ready_i,
  output logic                              regfile_alu_we_fw_o,
  output logic [ex_cfg_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_cfg_pkg::DATA_W-1:0]     regfile_alu_wdata_fw_o,
  output logic                              regfile_we_wb_o,
  output logic [ex_cfg_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [ex_cfg_pkg::DATA_W-1:0]     regfile_wdata_wb_o,
  output logic                              ex_ready_o,
  output logic                              ex_valid_o
);

  logic units_ready;
  logic lsu_we;

  //////////////////////////////
  // forwarding port
  //////////////////////////////

  // enable and address straight from ID
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // csr wins over mult, mult over alu
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////
  // ex/wb register
  //////////////////////////////

  // faulting loads never write back
  assign lsu_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid_o) begin
      // wb_ready_i already folded into ex_valid_o
      regfile_we_wb_o <= lsu_we;
      if (lsu_we) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // nothing new, drain the slot
      regfile_we_wb_o <= 1'b0;
    end
  end

  // load data goes by without a register
  assign regfile_wdata_wb_o = lsu_rdata_i;

  //////////////////////////////
  // stall handshake
  //////////////////////////////

  assign units_ready = alu_ready_i & mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // branches retire in EX, so they free the stage
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // no ex_ready_o term here
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // an errored load in a valid cycle leaves the lsu port idle next cycle
  a_err_no_write : assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_o && lsu_err_i) |=> !regfile_we_wb_o)
    else $error("lsu write back after load error");

endmodule : ex_writeback

//--- source/ex_stage.sv
// execute stage top: alu, multiplier and write back with stall handshake
module ex_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  // alu issue
  input  logic                              alu_en_i,
  input  ex_types_pkg::alu_op_e             alu_operator_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     alu_operand_a_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     alu_operand_b_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     alu_operand_c_i,
  // mult issue
  input  logic                              mult_en_i,
  input  ex_types_pkg::mul_op_e             mult_operator_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     mult_operand_a_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     mult_operand_b_i,
  // csr read
  input  logic                              csr_access_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     csr_rdata_i,
  // lsu
  input  logic                              lsu_en_i,
  input  logic [ex_cfg_pkg::DATA_W-1:0]     lsu_rdata_i,
  input  logic                              lsu_ready_ex_i,
  input  logic                              lsu_err_i,
  // destination registers
  input  logic                              regfile_alu_we_i,
  input  logic [ex_cfg_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                              regfile_we_i,
  input  logic [ex_cfg_pkg::REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                              branch_in_ex_i,
  input  logic                              wb_ready_i,
  // forwarding port to ID and regfile
  output logic                              regfile_alu_we_fw_o,
  output logic [ex_cfg_pkg::REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [ex_cfg_pkg::DATA_W-1:0]     regfile_alu_wdata_fw_o,
  // lsu write port
  output logic                              regfile_we_wb_o,
  output logic [ex_cfg_pkg::REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [ex_cfg_pkg::DATA_W-1:0]     regfile_wdata_wb_o,
  // to IF
  output logic                              branch_decision_o,
  output logic [ex_cfg_pkg::DATA_W-1:0]     jump_target_o,
  output logic                              mult_multicycle_o,
  output logic                              ex_ready_o,
  output logic                              ex_valid_o
);
  import ex_cfg_pkg::*;

  logic [DATA_W-1:0] alu_result;
  logic [DATA_W-1:0] mult_result;
  logic              alu_ready;
  logic              mult_ready;

  // target already computed in ID
  assign jump_target_o = alu_operand_c_i;

  //////////////////////////////
  // alu
  //////////////////////////////

  ex_alu u_alu (
    .enable_i            (alu_en_i),
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .result_o            (alu_result),
    .comparison_result_o (branch_decision_o),
    .ready_o             (alu_ready)
  );

  //////////////////////////////
  // multiplier
  //////////////////////////////

  // released by the stage handshake
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .multicycle_o (mult_multicycle_o),
    .ready_o      (mult_ready)
  );

  //////////////////////////////
  // write back and handshake
  //////////////////////////////

  ex_writeback u_wb (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .alu_result_i           (alu_result),
    .mult_en_i              (mult_en_i),
    .mult_result_i          (mult_result),
    .csr_access_i           (csr_access_i),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_en_i               (lsu_en_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .alu_ready_i            (alu_ready),
    .mult_ready_i           (mult_ready),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

  // a multiplier issue never starts alongside an alu issue
  a_mult_alu_excl : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(u_mult.enable_i) |-> !alu_en_i)
    else $error("mult and alu issued together");

endmodule : ex_stage

//--- verif/ex_stage_tb.sv
// execute stage testbench, replays golden vectors with random write back stalls
module ex_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ex_cfg_pkg::*;
  import ex_types_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;

  logic                  clk;
  logic                  rst_n;
  logic                  alu_en;
  alu_op_e               alu_operator;
  logic [DATA_W-1:0]     alu_a;
  logic [DATA_W-1:0]     alu_b;
  logic [DATA_W-1:0]     alu_c;
  logic                  mult_en;
  mul_op_e               mult_operator;
  logic [DATA_W-1:0]     mult_a;
  logic [DATA_W-1:0]     mult_b;
  logic                  csr_access;
  logic [DATA_W-1:0]     csr_rdata;
  logic                  lsu_en;
  logic [DATA_W-1:0]     lsu_rdata;
  logic                  lsu_ready_ex;
  logic                  lsu_err;
  logic                  regfile_alu_we;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr;
  logic                  regfile_we;
  logic [REG_ADDR_W-1:0] regfile_waddr;
  logic                  branch_in_ex;
  logic                  wb_ready;
  logic                  regfile_alu_we_fw;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw;
  logic [DATA_W-1:0]     regfile_alu_wdata_fw;
  logic                  regfile_we_wb;
  logic [REG_ADDR_W-1:0] regfile_waddr_wb;
  logic [DATA_W-1:0]     regfile_wdata_wb;
  logic                  branch_decision;
  logic [DATA_W-1:0]     jump_target;
  logic                  mult_multicycle;
  logic                  ex_ready;
  logic                  ex_valid;

  integer seed;
  int     errors;
  int     tests;
  int     passed;
  int     high_lines;
  logic   timed_out;

  ex_stage u_dut (
    .clk(clk), .rst_n(rst_n),
    .alu_en_i(alu_en), .alu_operator_i(alu_operator),
    .alu_operand_a_i(alu_a), .alu_operand_b_i(alu_b), .alu_operand_c_i(alu_c),
    .mult_en_i(mult_en), .mult_operator_i(mult_operator),
    .mult_operand_a_i(mult_a), .mult_operand_b_i(mult_b),
    .csr_access_i(csr_access), .csr_rdata_i(csr_rdata),
    .lsu_en_i(lsu_en), .lsu_rdata_i(lsu_rdata),
    .lsu_ready_ex_i(lsu_ready_ex), .lsu_err_i(lsu_err),
    .regfile_alu_we_i(regfile_alu_we), .regfile_alu_waddr_i(regfile_alu_waddr),
    .regfile_we_i(regfile_we), .regfile_waddr_i(regfile_waddr),
    .branch_in_ex_i(branch_in_ex), .wb_ready_i(wb_ready),
    .regfile_alu_we_fw_o(regfile_alu_we_fw), .regfile_alu_waddr_fw_o(regfile_alu_waddr_fw),
    .regfile_alu_wdata_fw_o(regfile_alu_wdata_fw),
    .regfile_we_wb_o(regfile_we_wb), .regfile_waddr_wb_o(regfile_waddr_wb),
    .regfile_wdata_wb_o(regfile_wdata_wb),
    .branch_decision_o(branch_decision), .jump_target_o(jump_target),
    .mult_multicycle_o(mult_multicycle), .ex_ready_o(ex_ready), .ex_valid_o(ex_valid)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [REG_ADDR_W-1:0] got,
                            input logic [REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // names the opcode on failure
  task automatic check_alu_op(input alu_op_e op, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch regfile_alu_wdata_fw_o for %s: got %h, expected %h",
               op.name(), got, exp);
      errors++;
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // nothing issued, stage free to drain
  task automatic drive_idle();
    alu_en            <= 1'b0;
    alu_operator      <= ALU_ADD;
    alu_a             <= '0;
    alu_b             <= '0;
    alu_c             <= '0;
    mult_en           <= 1'b0;
    mult_operator     <= MUL_MUL;
    mult_a            <= '0;
    mult_b            <= '0;
    csr_access        <= 1'b0;
    csr_rdata         <= '0;
    lsu_en            <= 1'b0;
    lsu_rdata         <= '0;
    lsu_ready_ex      <= 1'b1;
    lsu_err           <= 1'b0;
    regfile_alu_we    <= 1'b0;
    regfile_alu_waddr <= '0;
    regfile_we        <= 1'b0;
    regfile_waddr     <= '0;
    branch_in_ex      <= 1'b0;
    wb_ready          <= 1'b1;
  endtask

  // cycle k expects ready and valid once k reaches exp_low
  // wb_ready released after stall cycles
  task automatic wait_ready(input int exp_low, input int stall, input logic high_mul,
                            input logic [DATA_W-1:0] exp_res, output logic ok);
    int k;
    k  = 0;
    ok = 1'b0;
    while (!ok && k < TIMEOUT_CYCLES) begin
      @(negedge clk);
      check_bit("ex_ready_o", ex_ready, k >= exp_low);
      check_bit("ex_valid_o", ex_valid, k >= exp_low);
      // stalled high product must hold its upper word
      if (high_mul && k >= 1 && !ex_ready) begin
        check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw, exp_res);
      end
      if (ex_ready) begin
        ok = 1'b1;
      end else begin
        @(posedge clk);
        k++;
        if (k >= stall) begin
          wb_ready <= 1'b1;
        end
      end
    end
  endtask

  task automatic run_line(input logic [23:0] kind, input logic [31:0] op_v,
                          input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                          input logic [DATA_W-1:0] c,
                          input logic [REG_ADDR_W-1:0] alu_waddr_v,
                          input logic [REG_ADDR_W-1:0] waddr_v, input logic err_v,
                          input logic [DATA_W-1:0] exp_res, input logic exp_flag);
    logic [31:0] r;
    int          stall;
    int          exp_low;
    logic        high_mul;
    logic        ok;
    int          errs_before;
    errs_before = errors;
    // about three lines in eight see a wb stall of 1 to 3 cycles
    r        = $random(seed);
    stall    = r[0] ? 0 : int'(r[2:1]);
    high_mul = (kind == "mul") && (op_v[1:0] != 2'd0);
    // high products alternate between a short and a long stall
    // short shows the single busy cycle, long shows the held result
    if (high_mul) begin
      stall = high_lines[0] ? 2 + int'(r[1]) : int'(r[1]);
      high_lines++;
    end
    // high product always costs one busy cycle
    exp_low  = (high_mul && stall == 0) ? 1 : stall;
    @(posedge clk);
    wb_ready          <= (stall == 0);
    alu_en            <= (kind == "alu");
    alu_operator      <= alu_op_e'(op_v[4:0]);
    alu_a             <= a;
    alu_b             <= b;
    alu_c             <= c;
    mult_en           <= (kind == "mul");
    mult_operator     <= mul_op_e'(op_v[1:0]);
    mult_a            <= a;
    mult_b            <= b;
    csr_access        <= (kind == "csr");
    csr_rdata         <= a;
    lsu_en            <= (kind == "lsu");
    lsu_rdata         <= a;
    lsu_err           <= err_v;
    regfile_alu_we    <= (kind != "lsu");
    regfile_alu_waddr <= alu_waddr_v;
    regfile_we        <= (kind == "lsu");
    regfile_waddr     <= waddr_v;
    wait_ready(exp_low, stall, high_mul, exp_res, ok);
    if (!ok) begin
      $display("timeout: ex_ready_o stayed low for %0d cycles", TIMEOUT_CYCLES);
      errors++;
      timed_out = 1'b1;
    end else begin
      case (kind)
        "alu": begin
          check_alu_op(alu_op_e'(op_v[4:0]), regfile_alu_wdata_fw, exp_res);
          check_bit("branch_decision_o", branch_decision, exp_flag);
          check_word("jump_target_o", jump_target, c);
          check_bit("regfile_alu_we_fw_o", regfile_alu_we_fw, 1'b1);
          check_addr("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw, alu_waddr_v);
        end
        "mul": begin
          check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw, exp_res);
          check_bit("mult_multicycle_o", mult_multicycle, high_mul);
        end
        "csr": begin
          check_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw, exp_res);
          check_addr("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw, alu_waddr_v);
        end
        "lsu": begin
          check_word("regfile_wdata_wb_o", regfile_wdata_wb, exp_res);
          // ex/wb register not loaded before the next edge
          check_bit("regfile_we_wb_o", regfile_we_wb, 1'b0);
        end
        default: begin
          $display("unknown vector kind %s", kind);
          errors++;
        end
      endcase
    end
    // idle cycle, ex/wb register holds the issue by now
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    if (ok && kind == "lsu") begin
      check_bit("regfile_we_wb_o", regfile_we_wb, exp_flag);
      if (exp_flag) begin
        check_addr("regfile_waddr_wb_o", regfile_waddr_wb, waddr_v);
      end
    end
    tests++;
    if (errors == errs_before) begin
      passed++;
      $display("test %0d %s op %0d stall %0d: ok", tests, kind, op_v, stall);
    end else begin
      $display("test %0d %s op %0d stall %0d: FAIL", tests, kind, op_v, stall);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int                    fd;
    int                    code;
    string                 line;
    logic [23:0]           kind;
    logic [31:0]           op_v;
    logic [DATA_W-1:0]     a;
    logic [DATA_W-1:0]     b;
    logic [DATA_W-1:0]     c;
    logic [REG_ADDR_W-1:0] alu_waddr_v;
    logic [REG_ADDR_W-1:0] waddr_v;
    logic                  err_v;
    logic [DATA_W-1:0]     exp_res;
    logic                  exp_flag;
    seed       = 32'h0b1a_4906;
    errors     = 0;
    tests      = 0;
    passed     = 0;
    high_lines = 0;
    timed_out  = 1'b0;
    drive_idle();
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // reset state of the lsu port and multiplier
    check_bit("regfile_we_wb_o", regfile_we_wb, 1'b0);
    check_addr("regfile_waddr_wb_o", regfile_waddr_wb, '0);
    check_bit("mult_multicycle_o", mult_multicycle, 1'b0);
    fd = $fopen("verif/ex_stage_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden vector file");
      errors++;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        code = $fgets(line, fd);
        // skip blank and comment lines
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h", kind, op_v, a, b, c,
                         alu_waddr_v, waddr_v, err_v, exp_res, exp_flag);
          if (code == 10) begin
            run_line(kind, op_v, a, b, c, alu_waddr_v, waddr_v, err_v, exp_res, exp_flag);
          end else begin
            $display("golden vector line could not be parsed: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests, passed, tests - passed, errors);
    if (errors == 0 && tests > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : ex_stage_tb

//--- verif/ex_stage_golden.txt
# kind op a b c alu_waddr waddr lsu_err exp_result exp_flag
# op is the decimal alu_op_e or mul_op_e code, the rest hex; lsu flag is expected we
alu 0  00000005 00000007 00001000 01 00 0 0000000c 0
alu 1  00000003 00000005 00001004 02 00 0 fffffffe 0
alu 2  f0f0f0f0 ff00ff00 00001008 03 00 0 f000f000 0
alu 3  f0f0f0f0 0f000f00 0000100c 04 00 0 fff0fff0 0
alu 4  aaaa5555 ffff0000 00001010 05 00 0 55555555 0
alu 5  00000001 00000024 00001014 06 00 0 00000010 0
alu 6  80000000 0000001f 00001018 07 00 0 00000001 0
alu 7  80000000 00000004 0000101c 08 00 0 f8000000 0
alu 8  ffffffff 00000001 00001020 09 00 0 00000001 1
alu 9  ffffffff 00000001 00001024 0a 00 0 00000000 0
alu 16 12345678 12345678 00002000 0b 00 0 00000001 1
alu 17 12345678 12345679 00002004 0c 00 0 00000001 1
alu 18 00000001 80000000 00002008 0d 00 0 00000000 0
alu 19 00000001 80000000 0000200c 0e 00 0 00000001 1
alu 20 00000001 80000000 00002010 0f 00 0 00000001 1
alu 21 00000001 80000000 00002014 10 00 0 00000000 0
mul 0  00000007 00000006 00000000 11 00 0 0000002a 0
mul 1  ffffffff 00000002 00000000 12 00 0 ffffffff 0
mul 2  80000000 ffffffff 00000000 13 00 0 80000000 0
mul 3  ffffffff ffffffff 00000000 14 00 0 fffffffe 0
mul 1  80000000 80000000 00000000 15 00 0 40000000 0
csr 0  cafebabe 00000000 00000000 16 00 0 cafebabe 0
lsu 0  deadbeef 00000000 00000000 00 05 0 deadbeef 1
lsu 0  01234567 00000000 00000000 00 2a 1 01234567 0
lsu 0  89abcdef 00000000 00000000 00 3f 0 89abcdef 1

//--- filelist.f
source/ex_cfg_pkg.sv
source/ex_types_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_writeback.sv
source/ex_stage.sv
verif/ex_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
GOLDEN    ?= verif/ex_stage_golden.txt
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_STR  := *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(GOLDEN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_STR)'

clean:
	rm -rf $(BUILD_DIR)
